//--- bench/tb_astro.sv
/*
 * Testbench for the Astrocade input and audio glue
 * Table of loader, key, stick and column cases with expected rows,
 * plus random audio checked against the per-game mix rules
 */
`include "astro_consts.svh"

module tb_astro;

	import astro_pkg::*;

	// Cycles one table entry takes at most
	localparam int ENTRY_CYCLES = 16;

	// Short names for the table
	localparam logic [7:0] SZ = `GAME_SPACEZAP;
	localparam logic [7:0] GF = `GAME_GORF;
	localparam logic [7:0] RR = `GAME_ROBBY;
	localparam logic [7:0] C0 = `COL_0;
	localparam logic [7:0] C1 = `COL_1;
	localparam logic [7:0] C2 = `COL_2;
	localparam logic [7:0] C3 = `COL_3;
	// Sticks fixed, fixed with speech busy or random per entry
	localparam int FIXED = 0;
	localparam int TALK = 1;
	localparam int FREE = 2;
	localparam int NO_KEY = -1;

	// DUT inputs
	logic         clk_sys;
	logic         reset;
	logic         load_wr;
	logic [7:0]   load_index;
	logic [24:0]  load_addr;
	loader_byte_u load_data;
	logic [10:0]  ps2_key;
	logic [8:0]   joy0;
	logic [8:0]   joy1;
	logic [7:0]   col_select;
	logic         speech_busy;
	logic [7:0]   chip_l;
	logic [7:0]   chip_r;
	logic [15:0]  sample_l;
	logic [15:0]  sample_r;
	// DUT outputs
	logic [7:0]   row_data;
	logic [15:0]  audio_l;
	logic [15:0]  audio_r;

	// ====================
	// Case table held as parallel queues
	logic [7:0] t_game[$];
	logic [7:0] t_d2[$];
	logic [7:0] t_d3[$];
	int         t_mode[$];
	int         t_key[$];
	logic [8:0] t_joy0[$];
	logic [8:0] t_joy1[$];
	logic [7:0] t_col[$];
	// Rows with the key held and released
	logic [7:0] t_row[$];
	logic [7:0] t_rel[$];

	// Run state
	logic [31:0] seed;
	logic        toggle;
	int          checks;
	int          errors;
	int          cycles;
	int          cycle_limit;

	astro_input_top i_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_wr     (load_wr),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.ps2_key     (ps2_key),
		.joy0        (joy0),
		.joy1        (joy1),
		.col_select  (col_select),
		.speech_busy (speech_busy),
		.chip_l      (chip_l),
		.chip_r      (chip_r),
		.sample_l    (sample_l),
		.sample_r    (sample_r),
		.row_data    (row_data),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	always #4 clk_sys = ~clk_sys;

	// Watchdog sized from the table length
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// LCG returning the upper half of its state
	function automatic logic [15:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Gorf side is chip times 64 plus its top six bits plus a quarter of the sample
	function automatic logic [15:0] gorf_side(input logic [7:0] chip, input logic [15:0] sample);
		logic [15:0] scaled;
		scaled = 16'(chip) * 16'd64;
		return scaled + 16'(chip >> 2) + (sample >> 2);
	endfunction

	task automatic add_case(input logic [7:0] game, input logic [7:0] d2, input logic [7:0] d3,
		input int mode, input int key, input logic [8:0] j0, input logic [8:0] j1,
		input logic [7:0] col, input logic [7:0] row, input logic [7:0] rel);
		t_game.push_back(game);
		t_d2.push_back(d2);
		t_d3.push_back(d3);
		t_mode.push_back(mode);
		t_key.push_back(key);
		t_joy0.push_back(j0);
		t_joy1.push_back(j1);
		t_col.push_back(col);
		t_row.push_back(row);
		t_rel.push_back(rel);
	endtask

	// ====================
	// Checks
	task automatic check_row(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
		end
	endtask

	task automatic check_audio(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: %s expected %04h, got %04h", $time, name, expected, actual);
		end
	endtask

	// ====================
	// Drivers switch inputs on the falling edge
	task automatic write_loader(input logic [7:0] index, input logic [24:0] addr,
		input loader_byte_u data);
		@(negedge clk_sys);
		load_wr    = 1'b1;
		load_index = index;
		load_addr  = addr;
		load_data  = data;
		// Strobe lasts one rising edge
		@(negedge clk_sys);
		load_wr = 1'b0;
	endtask

	task automatic send_key(input int code, input logic pressed);
		@(negedge clk_sys);
		toggle  = ~toggle;
		ps2_key = {toggle, pressed, code[8:0]};
		@(negedge clk_sys);
	endtask

	task automatic run_audio(input logic [7:0] game);
		logic [15:0] r;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		@(negedge clk_sys);
		r        = next_random();
		chip_l   = r[7:0];
		chip_r   = r[15:8];
		sample_l = next_random();
		sample_r = next_random();
		case (game)
			`GAME_GORF: begin
				exp_l = gorf_side(chip_l, sample_l);
				exp_r = gorf_side(chip_r, sample_r);
			end
			`GAME_ROBBY: begin
				exp_l = {chip_l, chip_l};
				exp_r = {chip_r, chip_r};
			end
			// Mono from the left chip
			default: begin
				exp_l = {chip_l, chip_l};
				exp_r = exp_l;
			end
		endcase
		// Registered mix shows up one clock later
		@(negedge clk_sys);
		check_audio("audio_l", audio_l, exp_l);
		check_audio("audio_r", audio_r, exp_r);
	endtask

	task automatic run_case(input int i);
		logic [15:0] r;
		int          errors_before;
		errors_before = errors;
		@(negedge clk_sys);
		col_select = t_col[i];
		if (t_mode[i] == FREE) begin
			r           = next_random();
			joy0        = r[8:0];
			speech_busy = r[9];
			r           = next_random();
			joy1        = r[8:0];
		end else begin
			joy0        = t_joy0[i];
			joy1        = t_joy1[i];
			speech_busy = (t_mode[i] == TALK);
		end
		write_loader(`LOAD_IDX_GAME, 25'd0, t_game[i]);
		write_loader(`LOAD_IDX_DIP, 25'd3, t_d3[i]);
		write_loader(`LOAD_IDX_DIP, 25'd2, t_d2[i]);
		// Banks show one clock after the last strobe
		check_row("row_data loaded", row_data, t_rel[i]);
		// Stray bank 5 write must leave both banks alone
		write_loader(`LOAD_IDX_DIP, 25'd5, ~t_d3[i]);
		if (t_key[i] >= 0) begin
			check_row("row_data idle", row_data, t_rel[i]);
			send_key(t_key[i], 1'b1);
			check_row("row_data pressed", row_data, t_row[i]);
			send_key(t_key[i], 1'b0);
			check_row("row_data released", row_data, t_rel[i]);
		end else begin
			check_row("row_data", row_data, t_row[i]);
		end
		run_audio(t_game[i]);
		$display("test %0d: game %02h col %02h %s", i + 1, t_game[i], t_col[i],
			(errors == errors_before) ? "ok" : "mismatch");
	endtask

	// ====================
	// game, d2, d3, mode, key, joy0, joy1, col, row held, row released
	task automatic build_table();
		// Space Zap
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h075, 9'h000, 9'h000, C2, 8'hfe, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h072, 9'h000, 9'h000, C2, 8'hfd, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h074, 9'h000, 9'h000, C2, 8'hf7, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h029, 9'h000, 9'h000, C2, 8'hff, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h02d, 9'h000, 9'h000, C1, 8'hfe, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h034, 9'h000, 9'h000, C1, 8'hf7, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h005, 9'h000, 9'h000, C0, 8'he7, 8'hf7);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h01e, 9'h000, 9'h000, C0, 8'hd7, 8'hf7);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, 'h055, 9'h000, 9'h000, C2, 8'hff, 8'hff);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, NO_KEY, 9'h008, 9'h000, C2, 8'hfe, 8'hfe);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, NO_KEY, 9'h1c0, 9'h000, C0, 8'hc5, 8'hc5);
		add_case(SZ, 8'ha5, 8'h3c, FIXED, NO_KEY, 9'h000, 9'h010, C1, 8'hef, 8'hef);
		add_case(SZ, 8'ha5, 8'h3c, FREE, NO_KEY, 9'h000, 9'h000, C3, 8'h3c, 8'h3c);
		add_case(SZ, 8'ha5, 8'h3c, FREE, NO_KEY, 9'h000, 9'h000, 8'h10, 8'hff, 8'hff);
		add_case(SZ, 8'h02, 8'h3c, FIXED, NO_KEY, 9'h000, 9'h000, C0, 8'hff, 8'hff);
		add_case(SZ, 8'h02, 8'h3c, FIXED, 'h075, 9'h000, 9'h000, C2, 8'hde, 8'hdf);
		// Gorf
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h175, 9'h000, 9'h000, C2, 8'h3e, 8'h3f);
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h014, 9'h000, 9'h000, C2, 8'h2f, 8'h3f);
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h02b, 9'h000, 9'h000, C1, 8'h3d, 8'h3f);
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h01b, 9'h000, 9'h000, C1, 8'h3f, 8'h3f);
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h016, 9'h000, 9'h000, C0, 8'haf, 8'hbf);
		add_case(GF, 8'h06, 8'hc3, FIXED, 'h004, 9'h000, 9'h000, C0, 8'hbd, 8'hbf);
		add_case(GF, 8'h06, 8'hc3, TALK, NO_KEY, 9'h000, 9'h000, C2, 8'hbf, 8'hbf);
		add_case(GF, 8'h06, 8'hc3, TALK, NO_KEY, 9'h000, 9'h000, C1, 8'h3f, 8'h3f);
		add_case(GF, 8'h06, 8'hc3, TALK, NO_KEY, 9'h001, 9'h000, C2, 8'hb7, 8'hb7);
		add_case(GF, 8'h06, 8'hc3, FIXED, NO_KEY, 9'h000, 9'h004, C1, 8'h3d, 8'h3d);
		add_case(GF, 8'h06, 8'hc3, FREE, NO_KEY, 9'h000, 9'h000, C3, 8'hc3, 8'hc3);
		add_case(GF, 8'h06, 8'hc3, FREE, NO_KEY, 9'h000, 9'h000, 8'h00, 8'hff, 8'hff);
		add_case(GF, 8'h05, 8'hc3, FIXED, NO_KEY, 9'h000, 9'h000, C0, 8'hfb, 8'hfb);
		// Robby Roto
		add_case(RR, 8'h02, 8'h5a, FIXED, 'h06b, 9'h000, 9'h000, C2, 8'hfb, 8'hff);
		add_case(RR, 8'h02, 8'h5a, FIXED, 'h023, 9'h000, 9'h000, C1, 8'hfb, 8'hff);
		add_case(RR, 8'h02, 8'h5a, FIXED, 'h01c, 9'h000, 9'h000, C1, 8'hdf, 8'hff);
		add_case(RR, 8'h02, 8'h5a, FIXED, 'h006, 9'h000, 9'h000, C0, 8'h3f, 8'h7f);
		add_case(RR, 8'h02, 8'h5a, FIXED, 'h02e, 9'h000, 9'h000, C0, 8'h7d, 8'h7f);
		add_case(RR, 8'h02, 8'h5a, FIXED, NO_KEY, 9'h010, 9'h000, C2, 8'hdf, 8'hdf);
		add_case(RR, 8'h02, 8'h5a, FIXED, NO_KEY, 9'h000, 9'h002, C1, 8'hfb, 8'hfb);
		add_case(RR, 8'h02, 8'h5a, FREE, NO_KEY, 9'h000, 9'h000, C3, 8'h5a, 8'h5a);
		add_case(RR, 8'h02, 8'h5a, FREE, NO_KEY, 9'h000, 9'h000, 8'h03, 8'hff, 8'hff);
		add_case(RR, 8'h00, 8'h5a, FIXED, NO_KEY, 9'h000, 9'h000, C0, 8'h77, 8'h77);
		// No game and unknown game codes
		add_case(8'h00, 8'hff, 8'h81, FREE, NO_KEY, 9'h000, 9'h000, C0, 8'hff, 8'hff);
		add_case(8'h00, 8'hff, 8'h81, FREE, NO_KEY, 9'h000, 9'h000, C3, 8'hff, 8'hff);
		add_case(8'h00, 8'h00, 8'h00, FIXED, 'h075, 9'h000, 9'h000, C2, 8'hff, 8'hff);
		add_case(8'h05, 8'hff, 8'h81, FREE, NO_KEY, 9'h000, 9'h000, C2, 8'hff, 8'hff);
	endtask

	// ====================
	initial begin
		logic [15:0] r;
		int          errors_before;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		load_wr     = 1'b0;
		load_index  = '0;
		load_addr   = '0;
		load_data   = '0;
		ps2_key     = '0;
		joy0        = '0;
		joy1        = '0;
		col_select  = '0;
		speech_busy = 1'b0;
		chip_l      = '0;
		chip_r      = '0;
		sample_l    = '0;
		sample_r    = '0;
		seed        = 32'he5ec_470c;
		toggle      = 1'b0;
		checks      = 0;
		errors      = 0;
		cycles      = 0;
		build_table();
		cycle_limit = 4 * t_game.size() * ENTRY_CYCLES;

		// Reset for two cycles with live chip audio on the inputs
		@(negedge clk_sys);
		r      = next_random();
		chip_l = r[7:0];
		chip_r = r[15:8];
		@(negedge clk_sys);
		check_audio("audio_l", audio_l, 16'h0000);
		check_audio("audio_r", audio_r, 16'h0000);
		reset = 1'b0;

		// Every column idles high with no game yet
		errors_before = errors;
		for (int k = 0; k < 6; k++) begin
			@(negedge clk_sys);
			col_select = 8'h01 << k;
			@(negedge clk_sys);
			check_row("row_data", row_data, `ROW_IDLE);
		end
		$display("test 0: reset state %s", (errors == errors_before) ? "ok" : "mismatch");

		for (int i = 0; i < t_game.size(); i++) begin
			run_case(i);
		end

		$display("%0d tests, %0d checks, %0d errors", t_game.size() + 1, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- include/astro_consts.svh
/*
 * Astrocade input and audio glue constants
 * Loader indices, game codes, switch columns, button bits and PS/2 codes
 */
`ifndef ASTRO_CONSTS_SVH
`define ASTRO_CONSTS_SVH

// ====================
// Loader indices
`define LOAD_IDX_GAME   8'd1
`define LOAD_IDX_DIP    8'd254

// Game codes, anything else is no game
`define GAME_SPACEZAP   8'd3
`define GAME_GORF       8'd4
`define GAME_ROBBY      8'd6

// ====================
// Switch matrix columns strobed by the chip
`define COL_0           8'h01
`define COL_1           8'h02
`define COL_2           8'h04
`define COL_3           8'h08
`define ROW_IDLE        8'hff

// Bit positions in a 6-bit player vector
`define BTN_RIGHT       0
`define BTN_LEFT        1
`define BTN_DOWN        2
`define BTN_UP          3
`define BTN_FIRE1       4
`define BTN_FIRE2       5

// System bits in the 9-bit joystick word
`define JOY_START1      6
`define JOY_START2      7
`define JOY_COIN        8

// ====================
// PS/2 codes, arrows ignore the extended bit
`define KEY_UP          9'b?0111_0101
`define KEY_DOWN        9'b?0111_0010
`define KEY_LEFT        9'b?0110_1011
`define KEY_RIGHT       9'b?0111_0100
`define KEY_FIRE1       9'h014
`define KEY_FIRE2       9'h029
`define KEY_START1      9'h005
`define KEY_START1_ALT  9'h016
`define KEY_START2      9'h006
`define KEY_START2_ALT  9'h01e
`define KEY_COIN        9'h004
`define KEY_COIN_ALT    9'h02e
// Player 2 cluster
`define KEY_P2_UP       9'h02d
`define KEY_P2_DOWN     9'h02b
`define KEY_P2_LEFT     9'h023
`define KEY_P2_RIGHT    9'h034
`define KEY_P2_FIRE1    9'h01c
`define KEY_P2_FIRE2    9'h01b

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the Astrocade input and audio testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_astro -f sources.f -o sim_astro

# Simulation output goes to a log that decides the result
./obj_dir/sim_astro > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi
echo "Simulation clean"

//--- sources.f
+incdir+include
verilog/astro_pkg.sv
verilog/game_config.sv
verilog/ps2_buttons.sv
verilog/control_matrix.sv
verilog/audio_mix.sv
verilog/astro_input_top.sv
bench/tb_astro.sv

//--- verilog/astro_input_top.sv
/*
 * Astrocade input and audio glue
 * Loader config, PS/2 buttons, switch matrix and audio mixer
 */
module astro_input_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	// Loader
	input  logic                    load_wr,
	input  logic [7:0]              load_index,
	input  logic [24:0]             load_addr,
	input  astro_pkg::loader_byte_u load_data,
	// Keyboard and sticks
	input  logic [10:0]             ps2_key,
	input  logic [8:0]              joy0,
	input  logic [8:0]              joy1,
	// From the video/sound chip
	input  logic [7:0]              col_select,
	input  logic                    speech_busy,
	input  logic [7:0]              chip_l,
	input  logic [7:0]              chip_r,
	input  logic [15:0]             sample_l,
	input  logic [15:0]             sample_r,
	// Back to the chip and out
	output logic [7:0]              row_data,
	output logic [15:0]             audio_l,
	output logic [15:0]             audio_r
);

	import astro_pkg::*;

	// Configuration
	loader_byte_u game_id;
	loader_byte_u dip2;
	loader_byte_u dip3;
	// Keyboard buttons
	logic [5:0]   key_p1;
	logic [5:0]   key_p2;
	logic         key_start1;
	logic         key_start2;
	logic         key_coin;

	// ====================
	game_config i_game_config (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.game_id    (game_id),
		.dip2       (dip2),
		.dip3       (dip3)
	);

	ps2_buttons i_ps2_buttons (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.key_p1     (key_p1),
		.key_p2     (key_p2),
		.key_start1 (key_start1),
		.key_start2 (key_start2),
		.key_coin   (key_coin)
	);

	// Row is combinational back to the chip
	control_matrix i_control_matrix (
		.key_p1      (key_p1),
		.key_p2      (key_p2),
		.key_start1  (key_start1),
		.key_start2  (key_start2),
		.key_coin    (key_coin),
		.joy0        (joy0),
		.joy1        (joy1),
		.game_id     (game_id),
		.dip2        (dip2),
		.dip3        (dip3),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

	audio_mix i_audio_mix (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.game_id  (game_id),
		.chip_l   (chip_l),
		.chip_r   (chip_r),
		.sample_l (sample_l),
		.sample_r (sample_r),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

endmodule

//--- verilog/astro_pkg.sv
/*
 * Astrocade glue package
 * Shared type for the loader data byte
 */
package astro_pkg;

	// ====================
	// Loader byte
	//
	// One byte from the loader, read two ways
	// Under the game index it is a game code
	// Under the DIP index it is a bank of eight switches
	//
	// Game view
	//   Whole byte compared against the game codes
	//   Unknown values select no game
	//
	// Switch view
	//   Bit n is switch n of the bank
	//   Switches are read active high straight into the row byte
	typedef union packed {
		// Game code
		logic [7:0] game;
		// Individual switch bits
		logic [7:0] dip;
	} loader_byte_u;

endpackage

//--- verilog/audio_mix.sv
/*
 * Audio mixer
 * Registered per-game mix of chip audio and sample audio
 */
`include "astro_consts.svh"

module audio_mix (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  astro_pkg::loader_byte_u game_id,
	input  logic [7:0]              chip_l,
	input  logic [7:0]              chip_r,
	input  logic [15:0]             sample_l,
	input  logic [15:0]             sample_r,
	output logic [15:0]             audio_l,
	output logic [15:0]             audio_r
);

	// Mix modes from the game code
	logic stereo;
	logic plus_samples;

	assign stereo       = (game_id.game == `GAME_ROBBY);
	assign plus_samples = (game_id.game == `GAME_GORF);

	// Chip scaled by 64 with its top bits as fill
	// Speech sample taken down two bits so it sits under the chip
	function automatic logic [15:0] chip_plus_sample(input logic [7:0] chip,
		input logic [15:0] sample);
		chip_plus_sample = {2'b00, chip, chip[7:2]} + {2'b00, sample[15:2]};
	endfunction

	// ====================
	// Output registers
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (plus_samples) begin
			audio_l <= chip_plus_sample(chip_l, sample_l);
			audio_r <= chip_plus_sample(chip_r, sample_r);
		end else if (stereo) begin
			// Two chips, one per side
			audio_l <= {chip_l, chip_l};
			audio_r <= {chip_r, chip_r};
		end else begin
			// Mono, also used with no game
			audio_l <= {chip_l, chip_l};
			audio_r <= {chip_l, chip_l};
		end
	end

endmodule

//--- verilog/control_matrix.sv
/*
 * Switch matrix row builder
 * Merges keyboard and joystick buttons and returns the active-low row
 * byte of the selected game for the strobed column
 */
`include "astro_consts.svh"

module control_matrix (
	input  logic [5:0]              key_p1,
	input  logic [5:0]              key_p2,
	input  logic                    key_start1,
	input  logic                    key_start2,
	input  logic                    key_coin,
	input  logic [8:0]              joy0,
	input  logic [8:0]              joy1,
	input  astro_pkg::loader_byte_u game_id,
	input  astro_pkg::loader_byte_u dip2,
	input  astro_pkg::loader_byte_u dip3,
	input  logic                    speech_busy,
	input  logic [7:0]              col_select,
	output logic [7:0]              row_data
);

	// ====================
	// Merged buttons
	logic [5:0] btn1;
	logic [5:0] btn2;
	logic       start1;
	logic       start2;
	logic       coin;
	// Inverted stick directions, right left down up
	logic [3:0] dirs1;
	logic [3:0] dirs2;
	// Per game rows
	logic [7:0] sz_col0, sz_col1, sz_col2;
	logic [7:0] gf_col0, gf_col1, gf_col2;
	logic [7:0] rr_col0, rr_col1, rr_col2;

	assign btn1   = key_p1 | joy0[5:0];
	assign btn2   = key_p2 | joy1[5:0];
	// System buttons only come from stick 0
	assign start1 = key_start1 | joy0[`JOY_START1];
	assign start2 = key_start2 | joy0[`JOY_START2];
	assign coin   = key_coin | joy0[`JOY_COIN];

	assign dirs1 = ~{btn1[`BTN_RIGHT], btn1[`BTN_LEFT], btn1[`BTN_DOWN], btn1[`BTN_UP]};
	assign dirs2 = ~{btn2[`BTN_RIGHT], btn2[`BTN_LEFT], btn2[`BTN_DOWN], btn2[`BTN_UP]};

	// ====================
	// Space Zap layout
	assign sz_col0 = {2'b11, ~start2, ~start1, dip2.dip[1], 1'b1, ~coin, 1'b1};
	assign sz_col1 = {3'b111, ~btn2[`BTN_FIRE1], dirs2};
	assign sz_col2 = {2'b11, dip2.dip[0], ~btn1[`BTN_FIRE1], dirs1};

	// Gorf layout, speech busy on top of the P1 column
	assign gf_col0 = {dip2.dip[2], dip2.dip[0], ~start2, ~start1, 1'b1, dip2.dip[1], ~coin, 1'b1};
	assign gf_col1 = {3'b001, ~btn2[`BTN_FIRE1], dirs2};
	assign gf_col2 = {speech_busy, 2'b01, ~btn1[`BTN_FIRE1], dirs1};

	// Robby Roto layout, fire one bit higher
	assign rr_col0 = {1'b0, ~start2, ~start1, 1'b1, dip2.dip[1], 1'b1, ~coin, 1'b1};
	assign rr_col1 = {2'b11, ~btn2[`BTN_FIRE1], 1'b1, dirs2};
	assign rr_col2 = {2'b11, ~btn1[`BTN_FIRE1], 1'b1, dirs1};

	// ====================
	// Row select, same cycle as the column
	always_comb begin
		row_data = `ROW_IDLE;
		case (game_id.game)
			`GAME_SPACEZAP: begin
				case (col_select)
					`COL_0:  row_data = sz_col0;
					`COL_1:  row_data = sz_col1;
					`COL_2:  row_data = sz_col2;
					`COL_3:  row_data = dip3.dip;
					default: row_data = `ROW_IDLE;
				endcase
			end
			`GAME_GORF: begin
				case (col_select)
					`COL_0:  row_data = gf_col0;
					`COL_1:  row_data = gf_col1;
					`COL_2:  row_data = gf_col2;
					`COL_3:  row_data = dip3.dip;
					default: row_data = `ROW_IDLE;
				endcase
			end
			`GAME_ROBBY: begin
				case (col_select)
					`COL_0:  row_data = rr_col0;
					`COL_1:  row_data = rr_col1;
					`COL_2:  row_data = rr_col2;
					`COL_3:  row_data = dip3.dip;
					default: row_data = `ROW_IDLE;
				endcase
			end
			// No game, nothing pulled low
			default: row_data = `ROW_IDLE;
		endcase
	end

endmodule

//--- verilog/game_config.sv
/*
 * Game configuration latch
 * Holds the selected game code and the DIP switch banks written by the loader
 */
`include "astro_consts.svh"

module game_config (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    load_wr,
	input  logic [7:0]              load_index,
	input  logic [24:0]             load_addr,
	input  astro_pkg::loader_byte_u load_data,
	output astro_pkg::loader_byte_u game_id,
	output astro_pkg::loader_byte_u dip2,
	output astro_pkg::loader_byte_u dip3
);

	// ====================
	// Write decode
	logic game_wr;
	logic dip_wr;
	logic dip2_wr;
	logic dip3_wr;

	assign game_wr = load_wr && (load_index == `LOAD_IDX_GAME);
	assign dip_wr  = load_wr && (load_index == `LOAD_IDX_DIP);

	// Bank number is the loader address
	// Only banks 2 and 3 feed the kept games
	assign dip2_wr = dip_wr && (load_addr == 25'd2);
	assign dip3_wr = dip_wr && (load_addr == 25'd3);

	// ====================
	// Holding registers
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			// No game, all switches off
			game_id <= '0;
			dip2    <= '0;
			dip3    <= '0;
		end else begin
			if (game_wr) begin
				game_id.game <= load_data.game;
			end
			// Later writes simply overwrite the bank
			if (dip2_wr) begin
				dip2.dip <= load_data.dip;
			end
			if (dip3_wr) begin
				dip3.dip <= load_data.dip;
			end
		end
	end

endmodule

//--- verilog/ps2_buttons.sv
/*
 * PS/2 key decoder
 * Turns toggle-flagged key events into held player and system buttons
 */
`include "astro_consts.svh"

module ps2_buttons (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	output logic [5:0]  key_p1,
	output logic [5:0]  key_p2,
	output logic        key_start1,
	output logic        key_start2,
	output logic        key_coin
);

	// Key word fields
	logic       toggle;
	logic       pressed;
	logic [8:0] code;

	// Event detect
	logic toggle_last;
	logic key_event;

	assign toggle  = ps2_key[10];
	assign pressed = ps2_key[9];
	assign code    = ps2_key[8:0];

	// New event whenever the toggle bit moves
	assign key_event = (toggle != toggle_last);

	// ====================
	// Button state
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_last <= 1'b0;
			key_p1      <= '0;
			key_p2      <= '0;
			key_start1  <= 1'b0;
			key_start2  <= 1'b0;
			key_coin    <= 1'b0;
		end else begin
			toggle_last <= toggle;
			if (key_event) begin
				// Press sets, release clears
				casez (code)
					// Player 1 cluster
					`KEY_UP:      key_p1[`BTN_UP]    <= pressed;
					`KEY_DOWN:    key_p1[`BTN_DOWN]  <= pressed;
					`KEY_LEFT:    key_p1[`BTN_LEFT]  <= pressed;
					`KEY_RIGHT:   key_p1[`BTN_RIGHT] <= pressed;
					`KEY_FIRE1:   key_p1[`BTN_FIRE1] <= pressed;
					`KEY_FIRE2:   key_p1[`BTN_FIRE2] <= pressed;
					// Function keys and arcade-panel keys share a button
					`KEY_START1, `KEY_START1_ALT: key_start1 <= pressed;
					`KEY_START2, `KEY_START2_ALT: key_start2 <= pressed;
					`KEY_COIN, `KEY_COIN_ALT:     key_coin   <= pressed;
					// Player 2 cluster
					`KEY_P2_UP:    key_p2[`BTN_UP]    <= pressed;
					`KEY_P2_DOWN:  key_p2[`BTN_DOWN]  <= pressed;
					`KEY_P2_LEFT:  key_p2[`BTN_LEFT]  <= pressed;
					`KEY_P2_RIGHT: key_p2[`BTN_RIGHT] <= pressed;
					`KEY_P2_FIRE1: key_p2[`BTN_FIRE1] <= pressed;
					`KEY_P2_FIRE2: key_p2[`BTN_FIRE2] <= pressed;
					// Unknown codes leave everything alone
					default: ;
				endcase
			end
		end
	end

endmodule
